/* sim.f */
verilog/dmaPkg.sv
verilog/dmaStart.sv
verilog/dmaFsm.sv
verilog/dmaDatapath.sv
verilog/dmaChannel.sv
verilog/dmaBusArbiter.sv
verilog/dmaTop.sv
verification/tbClock.sv
verification/dmaBus_chk.sv
verification/dmaTb.sv

/* verification/dmaTb.sv */
`timescale 1ns/1ps

module dmaTb import dmaPkg::*; ();

  // about 700 cycles of tests, so this leaves a wide margin
  localparam int TimeoutCycles = 4000;

  logic clk;
  logic rst_b;
  logic [3:0][31:0] chanSrcAddr;
  logic [3:0][31:0] chanDstAddr;
  logic [3:0][13:0] chanCount;
  logic [3:0][15:0] chanControl;
  logic [15:0] hcount;
  logic [15:0] vcount;
  logic soundReq;
  logic reqValid;
  logic reqWrite;
  logic [31:0] reqAddr;
  logic [31:0] reqWdata;
  logic [1:0] reqSize;
  logic creditReturn;
  logic rdValid;
  logic [31:0] rdData;
  logic [3:0] irq;
  logic [3:0] enableClear;
  logic busy;

  logic [31:0] mem [0:1023];
  logic [31:0] logAddr[$];
  logic [31:0] logData[$];
  logic [31:0] rdWord[$];
  int rdDue[$];
  int crDue[$];
  int rdLast;
  int crLast;
  int irqSeen [4];
  int clrSeen [4];
  int cycles;
  int errors;
  int checks;
  int testsRun;
  int i;
  logic randomDelays;
  logic [31:0] rngState;

  tbClock clockGen (.clk, .rst_b);

  dmaTop dmaTop_inst (
    .clk, .rst_b, .chanSrcAddr, .chanDstAddr, .chanCount, .chanControl,
    .hcount, .vcount, .soundReq, .reqValid, .reqWrite, .reqAddr, .reqWdata,
    .reqSize, .creditReturn, .rdValid, .rdData, .irq, .enableClear, .busy
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int nextDelay();
    if (!randomDelays) return 1;
    rngState = xorshift(rngState);
    return 1 + int'(rngState % 4); // 1 to 4 cycles
  endfunction

  function automatic int maxInt(input int a, input int b);
    return (a > b) ? a : b;
  endfunction

  // every halfword in memory differs, high halves from low halves too
  function automatic logic [31:0] fillWord(input int w);
    return {16'hA000 + 16'(w), 16'h3000 + 16'(w)};
  endfunction

  function automatic logic [15:0] halfAt(input logic [31:0] addr);
    logic [31:0] w;
    w = fillWord(int'(addr[11:2]));
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic [15:0] makeControl(input startMode sm, input addrMode srcM,
                                              input addrMode dstM, input logic word,
                                              input logic rep, input logic irqEn);
    logic [15:0] c;
    c = '0;
    c[EnableBit] = 1'b1;
    c[IrqEnableBit] = irqEn;
    c[StartModeHi:StartModeLo] = sm;
    c[WordSizeBit] = word;
    c[RepeatBit] = rep;
    c[SrcModeHi:SrcModeLo] = srcM;
    c[DstModeHi:DstModeLo] = dstM;
    return c;
  endfunction

  // memory port responses, driven 1 ns after the edge
  always @(posedge clk) begin
    #1;
    rdValid = 1'b0;
    creditReturn = 1'b0;
    if (rdDue.size() > 0 && rdDue[0] <= cycles) begin
      rdValid = 1'b1;
      rdData = rdWord.pop_front();
      void'(rdDue.pop_front());
    end
    if (crDue.size() > 0 && crDue[0] <= cycles) begin
      creditReturn = 1'b1;
      void'(crDue.pop_front());
    end
  end

  // requests sampled mid-cycle where the port is stable
  always @(negedge clk) begin
    if (rst_b && reqValid) begin
      crLast = maxInt(crLast + 1, cycles + nextDelay()); // one return per cycle, in order
      crDue.push_back(crLast);
      if (reqWrite) begin
        if (reqSize == 2'b10) mem[reqAddr[11:2]] = reqWdata;
        else if (reqAddr[1]) mem[reqAddr[11:2]][31:16] = reqWdata[31:16];
        else mem[reqAddr[11:2]][15:0] = reqWdata[15:0];
        logAddr.push_back(reqAddr);
        logData.push_back(reqWdata);
      end else begin
        rdLast = maxInt(rdLast + 1, cycles + nextDelay());
        rdDue.push_back(rdLast);
        rdWord.push_back(mem[reqAddr[11:2]]);
      end
    end
    for (int ch = 0; ch < 4; ch++) begin
      if (rst_b && irq[ch]) irqSeen[ch]++;
      if (rst_b && enableClear[ch]) clrSeen[ch]++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("timeout: the DUT did not finish within %0d cycles", TimeoutCycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) nextCycle();
  endtask

  task automatic checkWord(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkAddr(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic checkEntry(input string name, input int idx, input logic [31:0] expAddr,
                            input logic [31:0] expData);
    if (idx >= logAddr.size()) begin
      errors++;
      $display("%s: write %0d was never issued", name, idx);
    end else begin
      checkAddr($sformatf("%s write %0d address", name, idx), expAddr, logAddr[idx]);
      checkWord($sformatf("%s write %0d data", name, idx), expData, logData[idx]);
    end
  endtask

  task automatic startChannel(input int ch, input logic [31:0] src, input logic [31:0] dst,
                              input logic [13:0] count, input logic [15:0] control);
    chanSrcAddr[ch] = src;
    chanDstAddr[ch] = dst;
    chanCount[ch] = count;
    chanControl[ch] = control;
  endtask

  task automatic stopChannel(input int ch);
    chanControl[ch] = '0;
    idle(2);
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    testsRun++;
    $display("%s finished with %0d errors", name, errors - errsBefore);
  endtask

  task automatic copyWords(input string name, input logic randomized);
    int errs;
    int irqBase;
    int clrBase;
    int k;
    errs = errors;
    irqBase = irqSeen[0];
    clrBase = clrSeen[0];
    randomDelays = randomized;
    logAddr.delete();
    logData.delete();
    startChannel(0, 32'h100, 32'h800, 14'd8,
                 makeControl(Immediate, Increment, Increment, 1'b1, 1'b0, 1'b1));
    while (logAddr.size() == 0) nextCycle();
    checkFlag({name, " busy during transfer"}, 1'b1, busy);
    while (clrSeen[0] == clrBase) nextCycle();
    idle(8);
    checkFlag({name, " busy after done"}, 1'b0, busy);
    checkWord({name, " write count"}, 32'd8, 32'(logAddr.size()));
    for (k = 0; k < 8; k++)
      checkEntry(name, k, 32'h800 + 32'(4 * k), fillWord(64 + k));
    checkFlag({name, " irq once"}, 1'b1, irqSeen[0] - irqBase == 1);
    checkFlag({name, " enableClear once"}, 1'b1, clrSeen[0] - clrBase == 1);
    stopChannel(0);
    randomDelays = 1'b0;
    finishTest(name, errs);
  endtask

  task automatic halfwordReverse();
    string name;
    int errs;
    int clrBase;
    int k;
    logic [31:0] orig;
    name = "test2 halfword reverse";
    errs = errors;
    clrBase = clrSeen[0];
    logAddr.delete();
    logData.delete();
    startChannel(0, 32'h20E, 32'h902, 14'd6,
                 makeControl(Immediate, Decrement, Fixed, 1'b0, 1'b0, 1'b0));
    while (clrSeen[0] == clrBase) nextCycle();
    idle(4);
    checkWord({name, " write count"}, 32'd6, 32'(logAddr.size()));
    for (k = 0; k < 6; k++)
      checkEntry(name, k, 32'h902, {halfAt(32'h20E - 32'(2 * k)), 16'h0000}); // upper lane
    orig = fillWord(576);
    checkWord({name, " memory lanes"}, {halfAt(32'h204), orig[15:0]}, mem[576]);
    stopChannel(0);
    finishTest(name, errs);
  endtask

  task automatic vblankRepeat();
    string name;
    int errs;
    int irqBase;
    int clrBase;
    int k;
    name = "test3 vblank repeat";
    errs = errors;
    irqBase = irqSeen[0];
    clrBase = clrSeen[0];
    logAddr.delete();
    logData.delete();
    vcount = 16'd159;
    startChannel(0, 32'h300, 32'hA00, 14'd2,
                 makeControl(VBlank, Increment, IncReload, 1'b1, 1'b1, 1'b1));
    idle(10);
    checkWord({name, " writes before vblank"}, 32'd0, 32'(logAddr.size()));
    vcount = 16'd160;
    while (irqSeen[0] == irqBase) nextCycle();
    idle(12); // line still at 160, no second start
    checkWord({name, " writes after one edge"}, 32'd2, 32'(logAddr.size()));
    vcount = 16'd161;
    idle(2);
    vcount = 16'd160;
    while (irqSeen[0] < irqBase + 2) nextCycle();
    idle(4);
    checkWord({name, " write count"}, 32'd4, 32'(logAddr.size()));
    for (k = 0; k < 4; k++)
      checkEntry(name, k, 32'hA00 + 32'(4 * (k % 2)), fillWord(192 + k));
    checkFlag({name, " enable kept"}, 1'b0, clrSeen[0] != clrBase);
    stopChannel(0);
    vcount = 16'd0;
    finishTest(name, errs);
  endtask

  task automatic priorityPreempt();
    string name;
    int errs;
    int base0;
    int base3;
    int k;
    int idx0[$];
    int idx3[$];
    name = "test4 priority and preemption";
    errs = errors;
    base0 = clrSeen[0];
    base3 = clrSeen[3];
    logAddr.delete();
    logData.delete();
    startChannel(0, 32'h400, 32'hB00, 14'd4,
                 makeControl(Immediate, Increment, Increment, 1'b1, 1'b0, 1'b0));
    startChannel(3, 32'h500, 32'hC00, 14'd4,
                 makeControl(Immediate, Increment, Increment, 1'b1, 1'b0, 1'b0));
    while (clrSeen[0] == base0 || clrSeen[3] == base3) nextCycle();
    idle(4);
    checkWord({name, " write count"}, 32'd8, 32'(logAddr.size()));
    for (k = 0; k < 4; k++) begin
      checkEntry(name, k, 32'hB00 + 32'(4 * k), fillWord(256 + k));
      checkEntry(name, k + 4, 32'hC00 + 32'(4 * k), fillWord(320 + k));
    end
    stopChannel(0);
    stopChannel(3);

    // channel 0 arrives while channel 3 is running
    base0 = clrSeen[0];
    base3 = clrSeen[3];
    logAddr.delete();
    logData.delete();
    startChannel(3, 32'h500, 32'hC00, 14'd8,
                 makeControl(Immediate, Increment, Increment, 1'b1, 1'b0, 1'b0));
    while (logAddr.size() < 2) nextCycle();
    startChannel(0, 32'h400, 32'hB20, 14'd4,
                 makeControl(Immediate, Increment, Increment, 1'b1, 1'b0, 1'b0));
    while (clrSeen[0] == base0 || clrSeen[3] == base3) nextCycle();
    idle(4);
    for (k = 0; k < logAddr.size(); k++) begin
      if (logAddr[k] < 32'hC00) idx0.push_back(k);
      else idx3.push_back(k);
    end
    checkWord({name, " channel 0 writes"}, 32'd4, 32'(idx0.size()));
    checkWord({name, " channel 3 writes"}, 32'd8, 32'(idx3.size()));
    for (k = 0; k < idx0.size(); k++)
      checkEntry(name, idx0[k], 32'hB20 + 32'(4 * k), fillWord(256 + k));
    for (k = 0; k < idx3.size(); k++)
      checkEntry(name, idx3[k], 32'hC00 + 32'(4 * k), fillWord(320 + k));
    checkFlag({name, " channel 3 paused"}, 1'b1,
              idx0.size() > 0 && idx3.size() > 0 && idx0[0] > 0 && idx3[$] > idx0[$]);
    stopChannel(0);
    stopChannel(3);
    finishTest(name, errs);
  endtask

  task automatic soundFeed();
    string name;
    int errs;
    int irqBase;
    int clrBase;
    int k;
    name = "test5 sound feed";
    errs = errors;
    irqBase = irqSeen[1];
    clrBase = clrSeen[1];
    logAddr.delete();
    logData.delete();
    // count and size fields are ignored in this mode
    startChannel(1, 32'h600, 32'hD00, 14'd7,
                 makeControl(Special, Increment, Increment, 1'b0, 1'b0, 1'b1));
    idle(3);
    for (k = 0; k < 2; k++) begin
      soundReq = 1'b1;
      nextCycle();
      soundReq = 1'b0;
      while (irqSeen[1] < irqBase + k + 1) nextCycle();
    end
    idle(4);
    checkWord({name, " write count"}, 32'd8, 32'(logAddr.size()));
    for (k = 0; k < 8; k++)
      checkEntry(name, k, 32'hD00, fillWord(384 + k));
    checkFlag({name, " enable kept"}, 1'b0, clrSeen[1] != clrBase);
    stopChannel(1);
    finishTest(name, errs);
  endtask

  initial begin
    chanSrcAddr = '0;
    chanDstAddr = '0;
    chanCount = '0;
    chanControl = '0;
    hcount = '0;
    vcount = '0;
    soundReq = 1'b0;
    creditReturn = 1'b0;
    rdValid = 1'b0;
    rdData = '0;
    randomDelays = 1'b0;
    rngState = 32'hc9df24c8;
    for (i = 0; i < 1024; i++)
      mem[i] = fillWord(i);
    wait (rst_b === 1'b1);
    nextCycle();

    copyWords("test1 immediate word copy", 1'b0);
    halfwordReverse();
    vblankRepeat();
    priorityPreempt();
    soundFeed();
    copyWords("test6 random credit delays", 1'b1);

    errors += dmaTop_inst.arbiter.busChk.failCount;
    $display("%0d tests run, %0d checks, %0d errors", testsRun, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verification/dmaBus_chk.sv */
`timescale 1ns/1ps

module dmaBusChk #(
  parameter int NumChannels = 4,
  parameter int BusCredits  = 2
) (
  input logic                               clk,
  input logic                               rst_b,
  input logic [NumChannels-1:0]             lock,
  input logic [NumChannels-1:0]             grant,
  input logic                               reqValid,
  input logic                               creditReturn,
  input logic [$clog2(BusCredits + 1)-1:0]  credits
);

  int failCount = 0;

  // a wrapped counter shows up as a value above the pool
  creditRange: assert property (@(posedge clk) disable iff (!rst_b) credits <= BusCredits)
    else begin
      $error("more requests in flight than the bus has credits");
      failCount++;
    end

  issueNeedsCredit: assert property (@(posedge clk) disable iff (!rst_b)
    reqValid |-> (credits != '0 || creditReturn))
    else begin
      $error("request issued without a credit");
      failCount++;
    end

  reqKnown: assert property (@(posedge clk) disable iff (!rst_b) !$isunknown(reqValid))
    else begin
      $error("reqValid is unknown after reset");
      failCount++;
    end

  grantHeld: assert property (@(posedge clk) disable iff (!rst_b) (|lock) |=> $stable(grant))
    else begin
      $error("grant moved while a read-write pair was locked");
      failCount++;
    end

endmodule

bind dmaBusArbiter dmaBusChk #(.NumChannels(NumChannels), .BusCredits(BusCredits)) busChk (
  .clk, .rst_b, .lock, .grant, .reqValid, .creditReturn, .credits
);

/* verification/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rst_b
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  initial begin
    rst_b = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_b = 1'b1;
  end

endmodule

/* verilog/dmaTop.sv */
`timescale 1ns/1ps

module dmaTop #(
  parameter int                     NumChannels = 4,
  parameter logic [NumChannels-1:0] SoundMask   = 4'b0110,
  parameter int                     BusCredits  = 2
) (
  input  logic                         clk,
  input  logic                         rst_b,
  input  logic [NumChannels-1:0][31:0] chanSrcAddr,
  input  logic [NumChannels-1:0][31:0] chanDstAddr,
  input  logic [NumChannels-1:0][13:0] chanCount,
  input  logic [NumChannels-1:0][15:0] chanControl,
  input  logic [15:0]                  hcount,
  input  logic [15:0]                  vcount,
  input  logic                         soundReq,
  output logic                         reqValid,
  output logic                         reqWrite,
  output logic [31:0]                  reqAddr,
  output logic [31:0]                  reqWdata,
  output logic [1:0]                   reqSize,
  input  logic                         creditReturn,
  input  logic                         rdValid,
  input  logic [31:0]                  rdData,
  output logic [NumChannels-1:0]       irq,
  output logic [NumChannels-1:0]       enableClear,
  output logic                         busy
);

  logic [NumChannels-1:0]       pending;
  logic [NumChannels-1:0]       lock;
  logic [NumChannels-1:0]       grant;
  logic [NumChannels-1:0]       canIssue;
  logic [NumChannels-1:0]       active;
  logic [NumChannels-1:0]       chReqValid;
  logic [NumChannels-1:0]       chReqWrite;
  logic [NumChannels-1:0][31:0] chReqAddr;
  logic [NumChannels-1:0][31:0] chReqWdata;
  logic [NumChannels-1:0][1:0]  chReqSize;

  for (genvar i = 0; i < NumChannels; i++) begin : chan
    dmaChannel #(.SoundCapable(SoundMask[i])) channel (
      .clk, .rst_b,
      .srcAddr(chanSrcAddr[i]), .dstAddr(chanDstAddr[i]),
      .count(chanCount[i]), .control(chanControl[i]),
      .hcount, .vcount, .soundReq,
      .grant(grant[i]), .canIssue(canIssue[i]), .rdValid, .rdData,
      .pending(pending[i]), .lock(lock[i]),
      .chReqValid(chReqValid[i]), .chReqWrite(chReqWrite[i]),
      .chReqAddr(chReqAddr[i]), .chReqWdata(chReqWdata[i]), .chReqSize(chReqSize[i]),
      .irq(irq[i]), .enableClear(enableClear[i]), .active(active[i])
    );
  end

  dmaBusArbiter #(.NumChannels(NumChannels), .BusCredits(BusCredits)) arbiter (
    .clk, .rst_b, .pending, .lock, .chReqValid, .chReqWrite, .chReqAddr,
    .chReqWdata, .chReqSize, .creditReturn, .grant, .canIssue,
    .reqValid, .reqWrite, .reqAddr, .reqWdata, .reqSize
  );

  assign busy = |active;

endmodule

/* verilog/dmaBusArbiter.sv */
`timescale 1ns/1ps

module dmaBusArbiter #(
  parameter int NumChannels = 4,
  parameter int BusCredits  = 2
) (
  input  logic                         clk,
  input  logic                         rst_b,
  input  logic [NumChannels-1:0]       pending,
  input  logic [NumChannels-1:0]       lock,
  input  logic [NumChannels-1:0]       chReqValid,
  input  logic [NumChannels-1:0]       chReqWrite,
  input  logic [NumChannels-1:0][31:0] chReqAddr,
  input  logic [NumChannels-1:0][31:0] chReqWdata,
  input  logic [NumChannels-1:0][1:0]  chReqSize,
  input  logic                         creditReturn,
  output logic [NumChannels-1:0]       grant,
  output logic [NumChannels-1:0]       canIssue,
  output logic                         reqValid,
  output logic                         reqWrite,
  output logic [31:0]                  reqAddr,
  output logic [31:0]                  reqWdata,
  output logic [1:0]                   reqSize
);

  localparam int CreditBits = $clog2(BusCredits + 1);

  logic [CreditBits-1:0]  credits;
  logic [NumChannels-1:0] cand;
  logic [NumChannels-1:0] pick;
  logic                   hold;
  logic                   creditOk;

  // the granted channel is still a candidate in its write cycle,
  // so it keeps the bus unless a lower-numbered channel is waiting
  assign cand = pending | (grant & {NumChannels{reqValid && reqWrite}});
  assign pick = cand & (~cand + 1'b1); // lowest set bit wins
  assign hold = (|lock) || (|(grant & pending));

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) grant <= '0;
    else if (!hold) grant <= pick;
  end

  assign creditOk = (credits != '0) || creditReturn;
  assign canIssue = grant & {NumChannels{creditOk}};

  always_comb begin
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr  = '0;
    reqWdata = '0;
    reqSize  = '0;
    for (int i = 0; i < NumChannels; i++) begin
      if (grant[i]) begin
        reqValid = chReqValid[i];
        reqWrite = chReqWrite[i];
        reqAddr  = chReqAddr[i];
        reqWdata = chReqWdata[i];
        reqSize  = chReqSize[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) credits <= CreditBits'(BusCredits);
    else credits <= credits - CreditBits'(reqValid) + CreditBits'(creditReturn);
  end

endmodule

/* verilog/dmaChannel.sv */
`timescale 1ns/1ps

module dmaChannel import dmaPkg::*; #(
  parameter bit SoundCapable = 1'b0
) (
  input  logic        clk,
  input  logic        rst_b,
  input  logic [31:0] srcAddr,
  input  logic [31:0] dstAddr,
  input  logic [13:0] count,
  input  logic [15:0] control,
  input  logic [15:0] hcount,
  input  logic [15:0] vcount,
  input  logic        soundReq,
  input  logic        grant,
  input  logic        canIssue,
  input  logic        rdValid,
  input  logic [31:0] rdData,
  output logic        pending,
  output logic        lock,
  output logic        chReqValid,
  output logic        chReqWrite,
  output logic [31:0] chReqAddr,
  output logic [31:0] chReqWdata,
  output logic [1:0]  chReqSize,
  output logic        irq,
  output logic        enableClear,
  output logic        active
);

  startMode mode;
  addrMode  srcMode;
  addrMode  dstMode;
  chanState state;
  logic enable;
  logic repeatMode;
  logic irqEnable;
  logic wordSize;
  logic soundFifo;
  logic start;
  logic load;
  logic reload;
  logic issueRead;
  logic issueWrite;
  logic latchData;
  logic stepSrc;
  logic stepDst;
  logic lastUnit;

  assign mode       = startMode'(control[StartModeHi:StartModeLo]);
  assign srcMode    = addrMode'(control[SrcModeHi:SrcModeLo]);
  assign dstMode    = addrMode'(control[DstModeHi:DstModeLo]);
  assign enable     = control[EnableBit];
  assign irqEnable  = control[IrqEnableBit];
  assign wordSize   = control[WordSizeBit];
  assign soundFifo  = SoundCapable && (mode == Special);
  assign repeatMode = control[RepeatBit] || soundFifo; // sound feed keeps its enable

  assign chReqValid = issueRead || issueWrite;
  assign chReqWrite = issueWrite;
  assign active     = (state != Off) && (state != Idle);

  dmaStart #(.SoundCapable(SoundCapable)) startGen (
    .clk, .rst_b, .mode, .hcount, .vcount, .soundReq,
    .armed(state != Off),
    .start
  );

  dmaFsm fsm (
    .clk, .rst_b, .enable, .repeatMode, .irqEnable, .start, .canIssue,
    .granted(grant), .rdValid, .lastUnit, .state, .load, .issueRead, .issueWrite,
    .latchData, .stepSrc, .stepDst, .reload, .pending, .lock, .irq, .enableClear
  );

  dmaDatapath #(.SoundCapable(SoundCapable)) datapath (
    .clk, .rst_b, .srcAddr, .dstAddr, .count, .srcMode, .dstMode, .mode, .wordSize,
    .load, .reload, .stepSrc, .stepDst, .latchData, .issueWrite, .rdData,
    .reqAddr(chReqAddr), .reqWdata(chReqWdata), .reqSize(chReqSize), .lastUnit
  );

endmodule

/* verilog/dmaDatapath.sv */
`timescale 1ns/1ps

module dmaDatapath import dmaPkg::*; #(
  parameter bit SoundCapable = 1'b0
) (
  input  logic        clk,
  input  logic        rst_b,
  input  logic [31:0] srcAddr,
  input  logic [31:0] dstAddr,
  input  logic [13:0] count,
  input  addrMode     srcMode,
  input  addrMode     dstMode,
  input  startMode    mode,
  input  logic        wordSize,
  input  logic        load,
  input  logic        reload,
  input  logic        stepSrc,
  input  logic        stepDst,
  input  logic        latchData,
  input  logic        issueWrite,
  input  logic [31:0] rdData,
  output logic [31:0] reqAddr,
  output logic [31:0] reqWdata,
  output logic [1:0]  reqSize,
  output logic        lastUnit
);

  logic        soundFifo;
  addrMode     dstModeEff;
  logic        wordEff;
  logic [31:0] stepSize;
  logic [14:0] unitsInit;
  logic [14:0] unitsLeft;
  logic [31:0] srcReg;
  logic [31:0] dstReg;
  logic [31:0] dataReg;

  function automatic logic [31:0] stepAddr(input logic [31:0] addr, input addrMode m,
                                           input logic [31:0] delta);
    case (m)
      Decrement: stepAddr = addr - delta;
      Fixed:     stepAddr = addr;
      default:   stepAddr = addr + delta; // Increment, IncReload
    endcase
  endfunction

  // sound FIFO feed: fixed dest, 4 words per request
  assign soundFifo  = SoundCapable && (mode == Special);
  assign dstModeEff = soundFifo ? Fixed : dstMode;
  assign wordEff    = soundFifo || wordSize;
  assign stepSize   = wordEff ? 32'd4 : 32'd2;

  always_comb begin
    if (soundFifo) unitsInit = 15'd4;
    else if (count == 14'd0) unitsInit = 15'd16384; // zero means max
    else unitsInit = {1'b0, count};
  end

  assign lastUnit = (unitsLeft == 15'd1);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) unitsLeft <= '0;
    else if (load || reload) unitsLeft <= unitsInit;
    else if (issueWrite) unitsLeft <= unitsLeft - 15'd1;
  end

  always_ff @(posedge clk) begin
    if (load) srcReg <= srcAddr;
    else if (stepSrc) srcReg <= stepAddr(srcReg, srcMode, stepSize);

    if (load || (reload && dstModeEff == IncReload)) dstReg <= dstAddr;
    else if (stepDst) dstReg <= stepAddr(dstReg, dstModeEff, stepSize);

    if (latchData) begin
      if (wordEff) dataReg <= rdData;
      else dataReg <= {16'h0000, srcReg[1] ? rdData[31:16] : rdData[15:0]};
    end
  end

  // halfword goes out on the lane of its destination
  always_comb begin
    if (wordEff) reqWdata = dataReg;
    else if (dstReg[1]) reqWdata = {dataReg[15:0], 16'h0000};
    else reqWdata = {16'h0000, dataReg[15:0]};
  end

  assign reqAddr = issueWrite ? dstReg : srcReg;
  assign reqSize = wordEff ? 2'b10 : 2'b01;

endmodule

/* verilog/dmaFsm.sv */
`timescale 1ns/1ps

module dmaFsm import dmaPkg::*; (
  input  logic     clk,
  input  logic     rst_b,
  input  logic     enable,
  input  logic     repeatMode,
  input  logic     irqEnable,
  input  logic     start,
  input  logic     canIssue,
  input  logic     granted,
  input  logic     rdValid,
  input  logic     lastUnit,
  output chanState state,
  output logic     load,
  output logic     issueRead,
  output logic     issueWrite,
  output logic     latchData,
  output logic     stepSrc,
  output logic     stepDst,
  output logic     reload,
  output logic     pending,
  output logic     lock,
  output logic     irq,
  output logic     enableClear
);

  chanState next;
  logic enableQ;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state   <= Off;
      enableQ <= 1'b0;
    end else begin
      state   <= next;
      enableQ <= enable;
    end
  end

  always_comb begin
    next        = state;
    load        = 1'b0;
    issueRead   = 1'b0;
    issueWrite  = 1'b0;
    latchData   = 1'b0;
    stepSrc     = 1'b0;
    stepDst     = 1'b0;
    reload      = 1'b0;
    pending     = 1'b0;
    lock        = 1'b0;
    irq         = 1'b0;
    enableClear = 1'b0;
    case (state)
      Off: begin
        if (enable && !enableQ) begin // rising edge of enable
          load = 1'b1;
          next = Idle;
        end
      end
      Idle: begin
        if (!enable) next = Off;
        else if (start) next = Queued;
      end
      Queued: begin
        pending = 1'b1;
        if (!enable) next = Off;
        else if (granted) next = Read;
      end
      Read: begin
        lock = 1'b1;
        if (canIssue) begin
          issueRead = 1'b1;
          next      = ReadWait;
        end
      end
      ReadWait: begin
        lock = 1'b1;
        if (rdValid) begin
          latchData = 1'b1;
          stepSrc   = 1'b1; // source address no longer needed for lane select
          next      = Write;
        end
      end
      Write: begin
        if (canIssue) begin
          // unit boundary, the arbiter may hand the bus to a higher channel here
          issueWrite = 1'b1;
          stepDst    = 1'b1;
          if (lastUnit) begin
            irq = irqEnable;
            if (repeatMode) begin
              reload = 1'b1;
              next   = Idle;
            end else begin
              enableClear = 1'b1;
              next        = Off;
            end
          end else if (!enable) begin
            next = Off;
          end else begin
            next = Queued; // back to Read next cycle if the grant stays
          end
        end else begin
          lock = 1'b1;
        end
      end
      default: next = Off;
    endcase
  end

endmodule

/* verilog/dmaStart.sv */
`timescale 1ns/1ps

module dmaStart import dmaPkg::*; #(
  parameter bit SoundCapable = 1'b0
) (
  input  logic        clk,
  input  logic        rst_b,
  input  startMode    mode,
  input  logic [15:0] hcount,
  input  logic [15:0] vcount,
  input  logic        soundReq,
  input  logic        armed,
  output logic        start
);

  logic cond;
  logic condQ;

  // level condition, the pulse comes from its rising edge
  always_comb begin
    cond = 1'b0;
    if (armed) begin
      case (mode)
        Immediate: cond = 1'b1; // rises once when the channel loads
        VBlank:    cond = (vcount == VBlankLine);
        HBlank:    cond = (hcount == HBlankLine);
        Special:   cond = SoundCapable && soundReq; // no video capture
        default:   cond = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      condQ <= 1'b0;
      start <= 1'b0;
    end else begin
      condQ <= cond;
      start <= cond && !condQ;
    end
  end

endmodule

/* verilog/dmaPkg.sv */
package dmaPkg;

  // start timing, bits 13:12 of the control word
  typedef enum logic [1:0] {
    Immediate = 2'b00,
    VBlank    = 2'b01,
    HBlank    = 2'b10,
    Special   = 2'b11
  } startMode;

  // address step modes for source and destination
  typedef enum logic [1:0] {
    Increment = 2'b00,
    Decrement = 2'b01,
    Fixed     = 2'b10,
    IncReload = 2'b11 // dest only: reload start address on repeat
  } addrMode;

  typedef enum logic [2:0] {
    Off      = 3'd0,
    Idle     = 3'd1,
    Queued   = 3'd2,
    Read     = 3'd3,
    ReadWait = 3'd4,
    Write    = 3'd5
  } chanState;

  // control word field positions
  localparam int DstModeLo    = 5;
  localparam int DstModeHi    = 6;
  localparam int SrcModeLo    = 7;
  localparam int SrcModeHi    = 8;
  localparam int RepeatBit    = 9;
  localparam int WordSizeBit  = 10;
  localparam int StartModeLo  = 12;
  localparam int StartModeHi  = 13;
  localparam int IrqEnableBit = 14;
  localparam int EnableBit    = 15;

  localparam logic [15:0] HBlankLine = 16'd240; // hcount
  localparam logic [15:0] VBlankLine = 16'd160; // vcount

endpackage
